// ==== compile.f ====
hw/tsn_desc_pkg.sv
hw/descriptor_select.sv
hw/input_queue.sv
hw/queue_config_regs.sv
hw/desc_ingress_top.sv
testbench/tb_desc_ingress.sv

// ==== hw/desc_ingress_top.sv ====
// Top level of the descriptor ingress path.
// Selector feeds the input queue; the register block sets the queue
// enable and drop mask and reads back level and counters.

module desc_ingress_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    // host source
    input  logic                            i_desc_wr_host,
    input  tsn_desc_pkg::tsn_desc_t         i_desc_host,
    output logic                            o_desc_ack_host,

    // network source
    input  logic                            i_desc_wr_net,
    input  tsn_desc_pkg::tsn_desc_t         i_desc_net,
    output logic                            o_desc_ack_net,

    // register port
    input  logic                            i_cfg_wr,
    input  logic                            i_cfg_rd,
    input  tsn_desc_pkg::cfg_addr_e         i_cfg_addr,
    input  logic [tsn_desc_pkg::CNT_W-1:0]  i_cfg_wdata,
    output logic [tsn_desc_pkg::CNT_W-1:0]  o_cfg_rdata,
    output logic                            o_cfg_rvalid,

    // queue read side
    input  logic                            i_q_pop,
    output tsn_desc_pkg::tsn_desc_t         o_q_desc,
    output logic                            o_q_valid
);

    import tsn_desc_pkg::*;

    // extra bit so a full queue can report its depth
    localparam int LEVEL_W = $clog2(QUEUE_DEPTH) + 1;

    tsn_desc_t          sel_desc;
    logic               sel_desc_wr;
    logic               enable;
    logic [7:0]         drop_mask;
    logic [LEVEL_W-1:0] level;
    logic [CNT_W-1:0]   accept_cnt;
    logic [CNT_W-1:0]   drop_cnt;

    descriptor_select u_select (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_desc_wr_host  (i_desc_wr_host),
        .i_desc_host     (i_desc_host),
        .o_desc_ack_host (o_desc_ack_host),
        .i_desc_wr_net   (i_desc_wr_net),
        .i_desc_net      (i_desc_net),
        .o_desc_ack_net  (o_desc_ack_net),
        .o_desc          (sel_desc),
        .o_desc_wr       (sel_desc_wr)
    );

    input_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .LEVEL_W     (LEVEL_W)
    ) u_queue (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_desc       (sel_desc),
        .i_desc_wr    (sel_desc_wr),
        .i_enable     (enable),
        .i_drop_mask  (drop_mask),
        .i_q_pop      (i_q_pop),
        .o_q_desc     (o_q_desc),
        .o_q_valid    (o_q_valid),
        .o_level      (level),
        .o_accept_cnt (accept_cnt),
        .o_drop_cnt   (drop_cnt)
    );

    queue_config_regs #(
        .LEVEL_W (LEVEL_W)
    ) u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_rd     (i_cfg_rd),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_cfg_rdata  (o_cfg_rdata),
        .o_cfg_rvalid (o_cfg_rvalid),
        .o_enable     (enable),
        .o_drop_mask  (drop_mask),
        .i_level      (level),
        .i_accept_cnt (accept_cnt),
        .i_drop_cnt   (drop_cnt)
    );

endmodule

// ==== hw/descriptor_select.sv ====
// Two-source descriptor selector in front of the input queue.
// Host and network ports hold a write level until acknowledged; the
// selector grants one at a time, host first, and emits a single
// registered write pulse with the descriptor and the matching ack.

module descriptor_select (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    input  logic                   i_desc_wr_host,
    input  tsn_desc_pkg::tsn_desc_t i_desc_host,
    output logic                   o_desc_ack_host,

    input  logic                   i_desc_wr_net,
    input  tsn_desc_pkg::tsn_desc_t i_desc_net,
    output logic                   o_desc_ack_net,

    output tsn_desc_pkg::tsn_desc_t o_desc,
    output logic                   o_desc_wr
);

    import tsn_desc_pkg::*;

    sel_state_e r_state;

    //************************************************************
    // grant fsm
    //************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state         <= SEL_IDLE;
            o_desc          <= '0;
            o_desc_wr       <= 1'b0;
            o_desc_ack_host <= 1'b0;
            o_desc_ack_net  <= 1'b0;
        end else begin
            // write pulse and acks last a single cycle
            o_desc          <= '0;
            o_desc_wr       <= 1'b0;
            o_desc_ack_host <= 1'b0;
            o_desc_ack_net  <= 1'b0;

            case (r_state)
                SEL_IDLE: begin
                    if (i_desc_wr_host) begin
                        o_desc          <= i_desc_host;
                        o_desc_wr       <= 1'b1;
                        o_desc_ack_host <= 1'b1;
                        r_state         <= SEL_HOST_HOLD;
                    end else if (i_desc_wr_net) begin
                        o_desc         <= i_desc_net;
                        o_desc_wr      <= 1'b1;
                        o_desc_ack_net <= 1'b1;
                        r_state        <= SEL_NET_HOLD;
                    end
                end
                // wait for the source to release its level-held request
                SEL_HOST_HOLD: begin
                    if (!i_desc_wr_host) begin
                        r_state <= SEL_IDLE;
                    end
                end
                SEL_NET_HOLD: begin
                    if (!i_desc_wr_net) begin
                        r_state <= SEL_IDLE;
                    end
                end
                default: begin
                    r_state <= SEL_IDLE;
                end
            endcase
        end
    end

    //************************************************************
    // checks
    //************************************************************
    // only one source is granted at a time
    a_one_ack: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_desc_ack_host && o_desc_ack_net)
    );

    // a level-held request is taken only once
    a_single_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_desc_wr |=> !o_desc_wr
    );

endmodule

// ==== hw/input_queue.sv ====
// Show-ahead descriptor FIFO of the ingress path.
// Admits a descriptor on each write pulse unless the queue is disabled,
// its type is masked or the queue is full, and keeps saturating
// accept and drop counters. The reader pops the head with i_q_pop.

module input_queue #(
    parameter int QUEUE_DEPTH = 8,
    parameter int LEVEL_W     = 4
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    input  tsn_desc_pkg::tsn_desc_t         i_desc,
    input  logic                            i_desc_wr,

    input  logic                            i_enable,
    input  logic [7:0]                      i_drop_mask,

    input  logic                            i_q_pop,
    output tsn_desc_pkg::tsn_desc_t         o_q_desc,
    output logic                            o_q_valid,

    output logic [LEVEL_W-1:0]              o_level,
    output logic [tsn_desc_pkg::CNT_W-1:0]  o_accept_cnt,
    output logic [tsn_desc_pkg::CNT_W-1:0]  o_drop_cnt
);

    import tsn_desc_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    tsn_desc_t          mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   r_wr_ptr;
    logic [PTR_W-1:0]   r_rd_ptr;
    logic [LEVEL_W-1:0] r_level;
    logic [CNT_W-1:0]   r_accept_cnt;
    logic [CNT_W-1:0]   r_drop_cnt;

    logic full;
    logic type_masked;
    logic push;
    logic drop;
    logic pop;

    //************************************************************
    // admit decision
    //************************************************************
    assign full        = (r_level == LEVEL_W'(QUEUE_DEPTH));
    assign type_masked = i_drop_mask[i_desc.pkt_type];

    // a disabled queue neither stores nor counts
    assign push = i_desc_wr && i_enable && !type_masked && !full;
    assign drop = i_desc_wr && i_enable && (type_masked || full);
    assign pop  = i_q_pop && o_q_valid;

    //************************************************************
    // storage and pointers
    //************************************************************
    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[r_wr_ptr] <= i_desc;
        end
    end

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_level  <= '0;
        end else begin
            if (push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   r_level <= r_level + 1'b1;
                2'b01:   r_level <= r_level - 1'b1;
                default: r_level <= r_level;
            endcase
        end
    end

    // saturating statistics
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_accept_cnt <= '0;
            r_drop_cnt   <= '0;
        end else begin
            if (push && (r_accept_cnt != '1)) begin
                r_accept_cnt <= r_accept_cnt + 1'b1;
            end
            if (drop && (r_drop_cnt != '1)) begin
                r_drop_cnt <= r_drop_cnt + 1'b1;
            end
        end
    end

    // head entry shown ahead of the pop
    assign o_q_desc     = mem[r_rd_ptr];
    assign o_q_valid    = (r_level != '0);
    assign o_level      = r_level;
    assign o_accept_cnt = r_accept_cnt;
    assign o_drop_cnt   = r_drop_cnt;

    //************************************************************
    // checks
    //************************************************************
    a_level_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        r_level <= LEVEL_W'(QUEUE_DEPTH)
    );

    // the reader must not pop an empty queue
    a_pop_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_q_pop |-> o_q_valid
    );

endmodule

// ==== hw/queue_config_regs.sv ====
// Configuration and status registers beside the input queue.
// Holds the queue enable and the per-type drop mask, and returns the
// queue level and both counters through a registered strobe read.

module queue_config_regs #(
    parameter int LEVEL_W = 4
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    input  logic                            i_cfg_wr,
    input  logic                            i_cfg_rd,
    input  tsn_desc_pkg::cfg_addr_e         i_cfg_addr,
    input  logic [tsn_desc_pkg::CNT_W-1:0]  i_cfg_wdata,
    output logic [tsn_desc_pkg::CNT_W-1:0]  o_cfg_rdata,
    output logic                            o_cfg_rvalid,

    output logic                            o_enable,
    output logic [7:0]                      o_drop_mask,

    input  logic [LEVEL_W-1:0]              i_level,
    input  logic [tsn_desc_pkg::CNT_W-1:0]  i_accept_cnt,
    input  logic [tsn_desc_pkg::CNT_W-1:0]  i_drop_cnt
);

    import tsn_desc_pkg::*;

    logic [CNT_W-1:0] rd_mux;

    // control fields, status addresses ignore writes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_enable    <= 1'b0;
            o_drop_mask <= '0;
        end else if (i_cfg_wr) begin
            case (i_cfg_addr)
                CFG_CTRL:      o_enable    <= i_cfg_wdata[0];
                CFG_DROP_MASK: o_drop_mask <= i_cfg_wdata[7:0];
                default:       ;
            endcase
        end
    end

    //************************************************************
    // read path
    //************************************************************
    always_comb begin
        case (i_cfg_addr)
            CFG_CTRL:       rd_mux = {{(CNT_W-1){1'b0}}, o_enable};
            CFG_DROP_MASK:  rd_mux = {{(CNT_W-8){1'b0}}, o_drop_mask};
            CFG_LEVEL:      rd_mux = CNT_W'(i_level);
            CFG_ACCEPT_CNT: rd_mux = i_accept_cnt;
            CFG_DROP_CNT:   rd_mux = i_drop_cnt;
            default:        rd_mux = '0;
        endcase
    end

    // data valid the cycle after the strobe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cfg_rdata  <= '0;
            o_cfg_rvalid <= 1'b0;
        end else begin
            o_cfg_rvalid <= i_cfg_rd;
            if (i_cfg_rd) begin
                o_cfg_rdata <= rd_mux;
            end
        end
    end

endmodule

// ==== hw/tsn_desc_pkg.sv ====
// Shared types for the TSN descriptor ingress path.
// Holds the descriptor layout, packet classes, selector states and the
// register map of the queue configuration block.
// Import with a wildcard inside a module body.

package tsn_desc_pkg;

    // width of the statistics counters and of the register data
    localparam int unsigned CNT_W = 16;

    // TSN packet classes, the drop mask is indexed by this value
    typedef enum logic [2:0] {
        PKT_TS   = 3'd0,
        PKT_RC   = 3'd1,
        PKT_BE   = 3'd2,
        PKT_PTP  = 3'd3,
        PKT_NMAC = 3'd4,
        PKT_RSV5 = 3'd5,
        PKT_RSV6 = 3'd6,
        PKT_RSV7 = 3'd7
    } pkt_type_e;

    // 60-bit descriptor as passed from a source port to the queue
    typedef struct packed {
        logic [47:0] tsntag;
        logic [8:0]  bufid;
        pkt_type_e   pkt_type;
    } tsn_desc_t;

    // descriptor selector states
    typedef enum logic [1:0] {
        SEL_IDLE      = 2'd0,
        SEL_HOST_HOLD = 2'd1,
        SEL_NET_HOLD  = 2'd2
    } sel_state_e;

    // register addresses of the configuration block
    typedef enum logic [2:0] {
        CFG_CTRL       = 3'd0,
        CFG_DROP_MASK  = 3'd1,
        CFG_LEVEL      = 3'd2,
        CFG_ACCEPT_CNT = 3'd3,
        CFG_DROP_CNT   = 3'd4
    } cfg_addr_e;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the descriptor ingress testbench with Verilator and run it.
# The result is taken from the pass line in the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_desc_ingress \
    -f compile.f \
    -o tb_desc_ingress_sim

./obj_dir/tb_desc_ingress_sim 2>&1 | tee "$LOG"

if grep -qx "RESULT: PASS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== testbench/tb_desc_ingress.sv ====
// Directed testbench for the descriptor ingress path.
// Drives both sources, the register port and the queue read side, and
// keeps a reference queue built from the admit rules of the queue.
// Prints one line per test and a closing summary.

module tb_desc_ingress;

    import tsn_desc_pkg::*;

    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 50;

    logic             i_clk;
    logic             i_rst_n;
    logic             i_desc_wr_host;
    tsn_desc_t        i_desc_host;
    logic             o_desc_ack_host;
    logic             i_desc_wr_net;
    tsn_desc_t        i_desc_net;
    logic             o_desc_ack_net;
    logic             i_cfg_wr;
    logic             i_cfg_rd;
    cfg_addr_e        i_cfg_addr;
    logic [CNT_W-1:0] i_cfg_wdata;
    logic [CNT_W-1:0] o_cfg_rdata;
    logic             o_cfg_rvalid;
    logic             i_q_pop;
    tsn_desc_t        o_q_desc;
    logic             o_q_valid;

    // reference queue and its control state
    tsn_desc_t  model_q[$];
    logic       model_enable;
    logic [7:0] model_mask;
    int         model_accepts;
    int         model_drops;

    logic [31:0] lfsr_state = 32'h548bc123;
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    desc_ingress_top #(
        .QUEUE_DEPTH (DEPTH)
    ) dut (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_desc_wr_host  (i_desc_wr_host),
        .i_desc_host     (i_desc_host),
        .o_desc_ack_host (o_desc_ack_host),
        .i_desc_wr_net   (i_desc_wr_net),
        .i_desc_net      (i_desc_net),
        .o_desc_ack_net  (o_desc_ack_net),
        .i_cfg_wr        (i_cfg_wr),
        .i_cfg_rd        (i_cfg_rd),
        .i_cfg_addr      (i_cfg_addr),
        .i_cfg_wdata     (i_cfg_wdata),
        .o_cfg_rdata     (o_cfg_rdata),
        .o_cfg_rvalid    (o_cfg_rvalid),
        .i_q_pop         (i_q_pop),
        .o_q_desc        (o_q_desc),
        .o_q_valid       (o_q_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    //************************************************************
    // random stimulus
    //************************************************************
    // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic logic [47:0] rand_bits(input int n);
        logic [47:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[46:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic pkt_type_e random_type();
        logic [2:0] t;
        t = 3'(rand_bits(3));
        return pkt_type_e'(t);
    endfunction

    function automatic tsn_desc_t random_desc(input pkt_type_e t);
        tsn_desc_t d;
        d.tsntag   = rand_bits(48);
        d.bufid    = 9'(rand_bits(9));
        d.pkt_type = t;
        return d;
    endfunction

    //************************************************************
    // checks and bookkeeping
    //************************************************************
    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("ERROR %s: %s", cur_test, msg);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, test_errs);
        end
    endtask

    // admit rule of the queue applied on each acknowledge
    task automatic model_admit(input tsn_desc_t d);
        if (model_enable) begin
            if (model_mask[d.pkt_type] || model_q.size() >= DEPTH) begin
                model_drops++;
            end else begin
                model_q.push_back(d);
                model_accepts++;
            end
        end
    endtask

    //************************************************************
    // bus tasks start and end on a falling edge
    //************************************************************
    task automatic cfg_write(input cfg_addr_e addr, input logic [CNT_W-1:0] data);
        i_cfg_wr    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(negedge i_clk);
        i_cfg_wr = 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_e addr, output logic [CNT_W-1:0] data);
        int waited;
        waited = 0;
        // let a push from the previous cycle reach the counters
        @(negedge i_clk);
        i_cfg_rd   = 1'b1;
        i_cfg_addr = addr;
        @(negedge i_clk);
        i_cfg_rd = 1'b0;
        while (!o_cfg_rvalid && waited < TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        check_true(o_cfg_rvalid, "register read gave no valid strobe");
        data = o_cfg_rdata;
    endtask

    task automatic check_reg(input cfg_addr_e addr, input logic [CNT_W-1:0] exp,
                             input string what);
        logic [CNT_W-1:0] data;
        cfg_read(addr, data);
        check_value(what, 64'(exp), 64'(data));
    endtask

    function automatic logic ack_of(input logic net);
        return net ? o_desc_ack_net : o_desc_ack_host;
    endfunction

    task automatic wait_ack(input logic net, output int waited, output logic seen);
        waited = 0;
        do begin
            @(negedge i_clk);
            waited++;
        end while (!ack_of(net) && waited < TIMEOUT);
        seen = ack_of(net);
        check_true(seen, "source was never acknowledged by the selector");
    endtask

    task automatic send_desc(input logic net, input tsn_desc_t d, output int waited);
        logic seen;
        // one idle cycle so the selector is back in idle
        @(negedge i_clk);
        if (net) begin
            i_desc_wr_net = 1'b1;
            i_desc_net    = d;
        end else begin
            i_desc_wr_host = 1'b1;
            i_desc_host    = d;
        end
        wait_ack(net, waited, seen);
        if (seen) begin
            model_admit(d);
        end
        if (net) begin
            i_desc_wr_net = 1'b0;
        end else begin
            i_desc_wr_host = 1'b0;
        end
    endtask

    task automatic expect_no_ack(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            check_true(!o_desc_ack_host && !o_desc_ack_net, "unexpected acknowledge");
        end
    endtask

    task automatic pop_head();
        int        waited;
        tsn_desc_t exp;
        waited = 0;
        while (!o_q_valid && waited < TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        check_true(o_q_valid, "queue head never became valid");
        check_true(model_q.size() > 0, "queue holds an entry that was not expected");
        if (o_q_valid && model_q.size() > 0) begin
            exp = model_q.pop_front();
            check_value("head", 64'(exp), 64'(o_q_desc));
            i_q_pop = 1'b1;
            @(negedge i_clk);
            i_q_pop = 1'b0;
        end
    endtask

    task automatic drain();
        int n;
        n = model_q.size();
        repeat (n) pop_head();
        check_value("valid after drain", 64'(0), 64'(o_q_valid));
    endtask

    //************************************************************
    // tests
    //************************************************************
    task automatic reset_defaults();
        start_test("reset_defaults");
        check_value("q_valid", 64'(0), 64'(o_q_valid));
        check_value("ack_host", 64'(0), 64'(o_desc_ack_host));
        check_value("ack_net", 64'(0), 64'(o_desc_ack_net));
        check_reg(CFG_CTRL, '0, "ctrl");
        check_reg(CFG_DROP_MASK, '0, "drop_mask");
        check_reg(CFG_LEVEL, '0, "level");
        check_reg(CFG_ACCEPT_CNT, '0, "accept_cnt");
        check_reg(CFG_DROP_CNT, '0, "drop_cnt");
        finish_test();
    endtask

    task automatic single_source_path();
        tsn_desc_t d;
        int        waited;
        start_test("single_source_path");
        cfg_write(CFG_CTRL, CNT_W'(1));
        model_enable = 1'b1;
        for (int s = 0; s < 2; s++) begin
            d = random_desc((s == 0) ? PKT_TS : PKT_PTP);
            send_desc(s == 1, d, waited);
            check_value("ack latency", 64'(1), 64'(waited));
            check_value("other ack", 64'(0), 64'(ack_of(s == 0)));
            // head is due two cycles after the request
            @(negedge i_clk);
            check_true(!o_desc_ack_host && !o_desc_ack_net, "acknowledge longer than one cycle");
            check_value("q_valid", 64'(1), 64'(o_q_valid));
            check_value("head at latency", 64'(d), 64'(o_q_desc));
            expect_no_ack(3);
            pop_head();
        end
        check_reg(CFG_ACCEPT_CNT, CNT_W'(2), "accept_cnt");
        finish_test();
    endtask

    task automatic host_priority_hold();
        tsn_desc_t dh;
        tsn_desc_t dn;
        int        waited;
        logic      seen;
        start_test("host_priority_hold");
        dh = random_desc(PKT_RC);
        dn = random_desc(PKT_TS);
        i_desc_host    = dh;
        i_desc_net     = dn;
        i_desc_wr_host = 1'b1;
        i_desc_wr_net  = 1'b1;
        wait_ack(1'b0, waited, seen);
        check_value("net ack beside host ack", 64'(0), 64'(o_desc_ack_net));
        if (seen) begin
            model_admit(dh);
        end
        // nothing else is granted while the host keeps its level up
        expect_no_ack(10);
        i_desc_wr_host = 1'b0;
        wait_ack(1'b1, waited, seen);
        check_true(waited >= 2, "network granted too soon after host release");
        if (seen) begin
            model_admit(dn);
        end
        i_desc_wr_net = 1'b0;
        expect_no_ack(3);
        check_reg(CFG_LEVEL, CNT_W'(2), "level");
        drain();
        finish_test();
    endtask

    task automatic type_filter();
        tsn_desc_t d;
        pkt_type_e t;
        int        waited;
        int        masked;
        int        drops_before;
        start_test("type_filter");
        masked       = 0;
        drops_before = model_drops;
        cfg_write(CFG_DROP_MASK, CNT_W'(8'h01 << PKT_BE));
        model_mask = 8'h01 << PKT_BE;
        for (int i = 0; i < 16; i++) begin
            // every fourth one is best effort for sure
            t = (i % 4 == 1) ? PKT_BE : random_type();
            if (model_mask[t]) begin
                masked++;
            end
            d = random_desc(t);
            send_desc(i % 2 == 1, d, waited);
            if (i == 7 || i == 15) begin
                drain();
            end
        end
        check_reg(CFG_DROP_CNT, CNT_W'(drops_before + masked), "drop_cnt");
        check_reg(CFG_LEVEL, '0, "level");
        cfg_write(CFG_DROP_MASK, '0);
        model_mask = '0;
        finish_test();
    endtask

    task automatic full_and_disable();
        tsn_desc_t d;
        int        waited;
        int        acc0;
        int        drop0;
        start_test("full_and_disable");
        acc0  = model_accepts;
        drop0 = model_drops;
        for (int i = 0; i < 10; i++) begin
            d = random_desc(random_type());
            send_desc(i % 2 == 1, d, waited);
        end
        check_reg(CFG_LEVEL, CNT_W'(DEPTH), "level when full");
        check_reg(CFG_ACCEPT_CNT, CNT_W'(acc0 + 8), "accept_cnt when full");
        check_reg(CFG_DROP_CNT, CNT_W'(drop0 + 2), "drop_cnt when full");
        // disabled queue ignores the descriptor and counts nothing
        cfg_write(CFG_CTRL, '0);
        model_enable = 1'b0;
        d = random_desc(PKT_TS);
        send_desc(1'b0, d, waited);
        check_reg(CFG_LEVEL, CNT_W'(DEPTH), "level when disabled");
        check_reg(CFG_ACCEPT_CNT, CNT_W'(acc0 + 8), "accept_cnt when disabled");
        check_reg(CFG_DROP_CNT, CNT_W'(drop0 + 2), "drop_cnt when disabled");
        drain();
        check_reg(CFG_LEVEL, '0, "level after drain");
        finish_test();
    endtask

    //************************************************************
    // main sequence
    //************************************************************
    initial begin
        i_rst_n        = 1'b0;
        i_desc_wr_host = 1'b0;
        i_desc_host    = '0;
        i_desc_wr_net  = 1'b0;
        i_desc_net     = '0;
        i_cfg_wr       = 1'b0;
        i_cfg_rd       = 1'b0;
        i_cfg_addr     = CFG_CTRL;
        i_cfg_wdata    = '0;
        i_q_pop        = 1'b0;
        model_enable   = 1'b0;
        model_mask     = '0;
        model_accepts  = 0;
        model_drops    = 0;
        total_errs     = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (3) @(negedge i_clk);
        i_rst_n = 1'b1;

        reset_defaults();
        single_source_path();
        host_priority_hold();
        type_filter();
        full_and_disable();

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
